/* files.f */
+incdir+rtl
rtl/pipe_pkg.sv
rtl/cp0_pkg.sv
rtl/dtlb_check.sv
rtl/cp0_regs.sv
rtl/m1_stage.sv
testbench/tb_m1_stage.sv

/* testbench/tb_m1_stage.sv */
`timescale 1ns/1ps
`include "m1_macros.svh"

module tb_m1_stage
    import pipe_pkg::*, cp0_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TXN    = 3000;

    logic          clk;
    logic          reset;
    logic          es_valid;
    es_to_m1_bus_t es_bus;
    logic          m1_allowin;
    logic          ms_allowin;
    logic          ms_valid;
    m1_to_ms_bus_t ms_bus;
    logic [5:0]    ext_int;
    tlb_entry_t    dtlb_entry;
    logic          dcache_busy;
    logic          dcache_valid;
    dcache_req_t   dcache_req;
    logic          flush;
    logic [31:0]   flush_pc;
    logic [4:0]    fwd_dest;

    // reference model state
    logic          m_valid;
    es_to_m1_bus_t m_bus;
    cp0_status_t   m_status;
    cp0_cause_t    m_cause;
    logic [31:0]   m_epc;
    logic [2:0]    m_k0;
    logic          e_ex;
    logic [4:0]    e_code;
    logic          e_allowin;
    logic          e_commit;
    logic          e_flush;
    logic [31:0]   lfsr;
    int            n_done;

    m1_stage uut (
        .clk          (clk),
        .reset        (reset),
        .es_valid     (es_valid),
        .es_bus       (es_bus),
        .m1_allowin   (m1_allowin),
        .ms_allowin   (ms_allowin),
        .ms_valid     (ms_valid),
        .ms_bus       (ms_bus),
        .ext_int      (ext_int),
        .dtlb_entry   (dtlb_entry),
        .dcache_busy  (dcache_busy),
        .dcache_valid (dcache_valid),
        .dcache_req   (dcache_req),
        .flush        (flush),
        .flush_pc     (flush_pc),
        .fwd_dest     (fwd_dest)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        #(NUM_TXN * 20 * CLK_PERIOD);
        abort_run("timeout: the stage did not complete all transactions in time");
    end

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_ms_bus(input m1_to_ms_bus_t exp, input m1_to_ms_bus_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL t=%0t ms_bus expected %h actual %h", $time, exp, act));
        end
    endtask

    task automatic check_dcache_req(input dcache_req_t exp, input dcache_req_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL t=%0t dcache_req expected %h actual %h", $time, exp, act));
        end
    endtask

    function automatic logic [31:0] cp0_read(input logic [4:0] num);
        case (num)
            `CP0_STATUS: return {16'b0, m_status.im, 6'b0, m_status.exl, m_status.ie};
            `CP0_CAUSE:  return {m_cause.bd, 15'b0, m_cause.ip, 1'b0, m_cause.exc_code, 2'b0};
            `CP0_EPC:    return m_epc;
            `CP0_CONFIG: return {29'b0, m_k0};
            default:     return 32'b0;
        endcase
    endfunction

    task automatic translate(input logic [31:0] va, input mem_op_t op, input tlb_entry_t e,
                             input logic [2:0] k0, output logic [19:0] tag, output logic unc,
                             output logic tex, output logic [4:0] code);
        tlb_page_t pg;
        pg   = va[12] ? e.page1 : e.page0;
        tex  = 1'b0;
        code = `EXC_NONE;
        if (va[31:30] == 2'b10) begin                 // kseg0 or kseg1
            tag = {3'b000, va[28:12]};
            unc = va[29] || k0 == `CACHE_UNCACHED;
        end else begin
            tag = pg.pfn;
            unc = pg.c == `CACHE_UNCACHED;
            if ((op.load || op.store) && (!e.found || !pg.v)) begin
                tex  = 1'b1;
                code = op.store ? `EXC_TLBS : `EXC_TLBL;
            end else if (op.store && !pg.d) begin
                tex  = 1'b1;
                code = `EXC_MOD;
            end
        end
    endtask

    task automatic check_cycle();
        logic          mem;
        logic [19:0]   tag;
        logic          unc;
        logic          tex;
        logic [4:0]    tcode;
        logic          rdy;
        logic          ms_v;
        m1_to_ms_bus_t eb;
        dcache_req_t   er;
        mem = m_bus.mem_op.load | m_bus.mem_op.store;
        translate(m_bus.result.raw, m_bus.mem_op, dtlb_entry, m_k0, tag, unc, tex, tcode);
        if (m_status.ie && !m_status.exl && (m_cause.ip & m_status.im) != 0) begin
            e_ex   = 1'b1;
            e_code = `EXC_INT;
        end else if (m_bus.ex) begin
            e_ex   = 1'b1;
            e_code = m_bus.exc_code;
        end else begin
            e_ex   = tex;
            e_code = tcode;
        end
        rdy       = e_ex || !mem || !dcache_busy;
        ms_v      = m_valid && rdy;
        e_allowin = !m_valid || (rdy && ms_allowin);
        e_commit  = ms_v && ms_allowin;
        e_flush   = e_commit && (e_ex || m_bus.eret);
        check_bit("m1_allowin", e_allowin, m1_allowin);
        check_bit("ms_valid", ms_v, ms_valid);
        check_bit("dcache_valid", m_valid && mem && !e_ex && !dcache_busy && ms_allowin,
                  dcache_valid);
        check_bit("flush", e_flush, flush);
        check_word("fwd_dest", {27'b0, m_valid ? m_bus.dest : 5'b0}, {27'b0, fwd_dest});
        if (e_flush) begin
            check_word("flush_pc", e_ex ? `EXC_VECTOR : m_epc, flush_pc);
        end
        if (m_valid) begin
            eb.pc           = m_bus.pc;
            eb.final_result = m_bus.mfc0 ? cp0_read(m_bus.cp0_reg) : m_bus.result.raw;
            eb.rt_value     = m_bus.rt_value;
            eb.dest         = m_bus.dest;
            eb.gr_we        = m_bus.gr_we;
            eb.mem_op       = m_bus.mem_op;
            eb.ex           = e_ex;
            check_ms_bus(eb, ms_bus);
            if (mem) begin
                er.op        = m_bus.mem_op.store;
                er.index     = m_bus.result.raw[11:4];
                er.tag       = tag;
                er.offset    = m_bus.result.raw[3:0];
                er.wstrb     = (e_ex || !m_bus.mem_op.store) ? 4'b0 : m_bus.wstrb;
                er.wdata     = m_bus.rt_value;
                er.load_size = m_bus.mem_op.is_byte ? 3'd0 : (m_bus.mem_op.is_half ? 3'd1 : 3'd2);
                er.uncached  = unc;
                check_dcache_req(er, dcache_req);
            end
        end
    endtask

    task automatic update_model();
        if (e_commit) begin
            n_done++;
            if (e_ex) begin
                m_status.exl     = 1'b1;
                m_cause.bd       = m_bus.bd;
                m_cause.exc_code = e_code;
                m_epc            = m_bus.bd ? m_bus.pc - 32'd4 : m_bus.pc;
            end else if (m_bus.eret) begin
                m_status.exl = 1'b0;
            end else if (m_bus.mtc0) begin
                case (m_bus.cp0_reg)
                    `CP0_STATUS: m_status = {m_bus.result.raw[15:8], m_bus.result.raw[1:0]};
                    `CP0_CAUSE:  m_cause.ip[1:0] = m_bus.result.raw[9:8];
                    `CP0_EPC:    m_epc = m_bus.result.raw;
                    `CP0_CONFIG: m_k0 = m_bus.result.raw[2:0];
                    default: begin
                    end
                endcase
            end
        end
        m_cause.ip[7:2] = ext_int;                    // hw lines latched every edge
        if (e_flush) begin
            m_valid = 1'b0;
        end else if (e_allowin) begin
            m_valid = es_valid;
            if (es_valid) begin
                m_bus = es_bus;
            end
        end
    endtask

    function automatic tlb_page_t random_page();
        tlb_page_t p;
        p.pfn = 20'(next_bits(20));
        p.c   = 3'(next_bits(3));
        p.d   = next_bits(2) != 0;
        p.v   = next_bits(2) != 0;
        return p;
    endfunction

    task automatic drive_random();
        es_to_m1_bus_t b;
        tlb_entry_t    e;
        logic [2:0]    kind;
        logic [1:0]    sz;
        b           = '0;
        kind        = 3'(next_bits(3));
        sz          = 2'(next_bits(2));
        b.pc        = next_bits(30) << 2;
        b.result    = next_bits(32);
        b.rt_value  = next_bits(32);
        b.dest      = 5'(next_bits(5));
        b.bd        = next_bits(2) == 0;
        b.ex        = next_bits(4) == 0;             // rare fault from an earlier stage
        b.exc_code  = 5'(next_bits(5));
        b.cp0_reg   = next_bits(1) ? (next_bits(1) ? `CP0_STATUS : `CP0_CAUSE)
                                   : (next_bits(1) ? `CP0_EPC : `CP0_CONFIG);
        case (kind)
            3'd0, 3'd6: begin
                b.mem_op = {1'b1, 1'b0, sz == 2'd0, sz == 2'd1, next_bits(1) == 1};
                b.gr_we  = 1'b1;
            end
            3'd1, 3'd7: begin
                b.mem_op = {1'b0, 1'b1, sz == 2'd0, sz == 2'd1, 1'b0};
                b.wstrb  = 4'(next_bits(4));
            end
            3'd2: b.mtc0 = 1'b1;
            3'd3: begin
                b.mfc0  = 1'b1;
                b.gr_we = 1'b1;
            end
            3'd4: b.eret = 1'b1;
            default: b.gr_we = 1'b1;
        endcase
        e.found = next_bits(3) != 0;
        e.page0 = random_page();
        e.page1 = random_page();
        es_valid    <= next_bits(2) != 0;
        es_bus      <= b;
        dtlb_entry  <= e;
        dcache_busy <= next_bits(2) == 0;
        ms_allowin  <= next_bits(2) != 0;
        ext_int     <= (next_bits(3) == 0) ? 6'(next_bits(6)) : 6'b0;
    endtask

    initial begin
        lfsr        = 32'hbc7a_d9ed;
        reset       = 1'b1;
        es_valid    = 1'b0;
        es_bus      = '0;
        ms_allowin  = 1'b0;
        dcache_busy = 1'b0;
        ext_int     = 6'b0;
        dtlb_entry  = '0;
        m_valid     = 1'b0;
        m_bus       = '0;
        m_status    = '0;
        m_cause     = '0;
        m_epc       = 32'b0;
        m_k0        = `CACHE_UNCACHED;
        e_ex        = 1'b0;
        e_code      = `EXC_NONE;
        e_allowin   = 1'b1;
        e_commit    = 1'b0;
        e_flush     = 1'b0;
        n_done      = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while (n_done < NUM_TXN) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            update_model();
            drive_random();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* rtl/m1_stage.sv */
`timescale 1ns/1ps
`include "m1_macros.svh"

module m1_stage
    import pipe_pkg::*, cp0_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          es_valid,
    input  es_to_m1_bus_t es_bus,
    output logic          m1_allowin,
    input  logic          ms_allowin,
    output logic          ms_valid,
    output m1_to_ms_bus_t ms_bus,
    input  logic [5:0]    ext_int,
    input  tlb_entry_t    dtlb_entry,
    input  logic          dcache_busy,
    output logic          dcache_valid,
    output dcache_req_t   dcache_req,
    output logic          flush,
    output logic [31:0]   flush_pc,
    output logic [4:0]    fwd_dest
);

    logic          m1_valid;
    es_to_m1_bus_t bus_r;
    logic          ready_go;
    logic          mem_access;
    logic          commit;
    logic          ex;
    logic [4:0]    exc_code;
    logic          int_pending;
    logic [31:0]   cp0_rdata;
    logic [31:0]   cp0_epc;
    logic [2:0]    k0;
    logic [19:0]   ptag;
    logic          uncached;
    logic          tlb_ex;
    logic [4:0]    tlb_exc_code;
    logic [31:0]   final_result;

    assign mem_access = bus_r.mem_op.load | bus_r.mem_op.store;
    assign ready_go   = ex || !mem_access || !dcache_busy;
    assign m1_allowin = !m1_valid || (ready_go && ms_allowin);
    assign ms_valid   = m1_valid && ready_go;
    assign commit     = ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            m1_valid <= 1'b0;
        end else if (flush) begin
            m1_valid <= 1'b0;                         // younger instruction is dropped
        end else if (m1_allowin) begin
            m1_valid <= es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_valid && m1_allowin) begin
            bus_r <= es_bus;
        end
    end

    dtlb_check u_dtlb_check (
        .vaddr    (bus_r.result.va),
        .mem_op   (bus_r.mem_op),
        .entry    (dtlb_entry),
        .k0       (k0),
        .ptag     (ptag),
        .uncached (uncached),
        .ex       (tlb_ex),
        .exc_code (tlb_exc_code)
    );

    cp0_regs u_cp0_regs (
        .clk         (clk),
        .reset       (reset),
        .commit      (commit),
        .reg_num     (bus_r.cp0_reg),
        .wdata       (bus_r.result.raw),
        .mtc0        (bus_r.mtc0),
        .eret        (bus_r.eret),
        .pc          (bus_r.pc),
        .bd          (bus_r.bd),
        .ex          (ex),
        .exc_code    (exc_code),
        .ext_int     (ext_int),
        .rdata       (cp0_rdata),
        .int_pending (int_pending),
        .epc         (cp0_epc),
        .k0          (k0)
    );

    // interrupt first, then older exceptions, then tlb fault
    always_comb begin
        if (int_pending) begin
            ex       = 1'b1;
            exc_code = `EXC_INT;
        end else if (bus_r.ex) begin
            ex       = 1'b1;
            exc_code = bus_r.exc_code;
        end else begin
            ex       = tlb_ex;
            exc_code = tlb_exc_code;
        end
    end

    assign flush    = commit && (ex || bus_r.eret);
    assign flush_pc = ex ? `EXC_VECTOR : cp0_epc;

    assign dcache_valid = m1_valid && mem_access && !ex && !dcache_busy && ms_allowin;

    always_comb begin
        dcache_req.op       = bus_r.mem_op.store;
        dcache_req.index    = bus_r.result.va.index;
        dcache_req.tag      = ptag;
        dcache_req.offset   = bus_r.result.va.offset;
        dcache_req.wstrb    = (ex || !bus_r.mem_op.store) ? 4'b0 : bus_r.wstrb;
        dcache_req.wdata    = bus_r.rt_value;
        dcache_req.uncached = uncached;
        if (bus_r.mem_op.is_byte) begin
            dcache_req.load_size = 3'd0;
        end else if (bus_r.mem_op.is_half) begin
            dcache_req.load_size = 3'd1;
        end else begin
            dcache_req.load_size = 3'd2;
        end
    end

    assign final_result = bus_r.mfc0 ? cp0_rdata : bus_r.result.raw;
    assign fwd_dest     = bus_r.dest & {5{m1_valid}};   // no forward from an empty stage

    assign ms_bus.pc           = bus_r.pc;
    assign ms_bus.final_result = final_result;
    assign ms_bus.rt_value     = bus_r.rt_value;
    assign ms_bus.dest         = bus_r.dest;
    assign ms_bus.gr_we        = bus_r.gr_we;
    assign ms_bus.mem_op       = bus_r.mem_op;
    assign ms_bus.ex           = ex;

    // a clean memory op waiting on the cache stays put
    a_busy_holds: assert property (
        @(posedge clk) disable iff (reset)
        (m1_valid && mem_access && !ex && dcache_busy)
            |-> !ms_valid ##1 (m1_valid && $stable(bus_r))
    ) else $error("memory op left the stage while dcache busy");

    a_req_clean: assert property (
        @(posedge clk) disable iff (reset)
        dcache_valid |-> !tlb_ex && !int_pending && !bus_r.ex && !flush
    ) else $error("dcache request issued for an excepting instruction");

endmodule

/* rtl/cp0_regs.sv */
`timescale 1ns/1ps
`include "m1_macros.svh"

module cp0_regs
    import cp0_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        commit,
    input  logic [4:0]  reg_num,
    input  logic [31:0] wdata,
    input  logic        mtc0,
    input  logic        eret,
    input  logic [31:0] pc,
    input  logic        bd,
    input  logic        ex,
    input  logic [4:0]  exc_code,
    input  logic [5:0]  ext_int,
    output logic [31:0] rdata,
    output logic        int_pending,
    output logic [31:0] epc,
    output logic [2:0]  k0
);

    cp0_status_t status;
    cp0_cause_t  cause;

    assign int_pending = status.ie && !status.exl && |(cause.ip & status.im);

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
            cause  <= '0;
            epc    <= '0;
            k0     <= `CACHE_UNCACHED;                // boot uncached
        end else begin
            cause.ip[7:2] <= ext_int;                 // hw lines sampled every cycle
            if (commit && ex) begin
                status.exl     <= 1'b1;
                cause.bd       <= bd;
                cause.exc_code <= exc_code;
                epc            <= bd ? pc - 32'd4 : pc; // back to the branch
            end else if (commit && eret) begin
                status.exl <= 1'b0;
            end else if (commit && mtc0) begin
                case (reg_num)
                    `CP0_STATUS: begin
                        status.im  <= wdata[15:8];
                        status.exl <= wdata[1];
                        status.ie  <= wdata[0];
                    end
                    `CP0_CAUSE: begin
                        cause.ip[1:0] <= wdata[9:8];  // only sw bits writable
                    end
                    `CP0_EPC: begin
                        epc <= wdata;
                    end
                    `CP0_CONFIG: begin
                        k0 <= wdata[2:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (reg_num)
            `CP0_STATUS: begin
                rdata = {16'b0, status.im, 6'b0, status.exl, status.ie};
            end
            `CP0_CAUSE: begin
                rdata = {cause.bd, 15'b0, cause.ip, 1'b0, cause.exc_code, 2'b0};
            end
            `CP0_EPC: begin
                rdata = epc;
            end
            `CP0_CONFIG: begin
                rdata = {29'b0, k0};
            end
            default: begin
                rdata = 32'b0;
            end
        endcase
    end

    // epc is only ever touched by a committing instruction
    a_epc_on_commit: assert property (
        @(posedge clk) disable iff (reset)
        !$past(commit) |-> $stable(epc)
    ) else $error("epc changed without a commit");

endmodule

/* rtl/dtlb_check.sv */
`timescale 1ns/1ps
`include "m1_macros.svh"

module dtlb_check
    import pipe_pkg::*, cp0_pkg::*;
(
    input  vaddr_t      vaddr,
    input  mem_op_t     mem_op,
    input  tlb_entry_t  entry,
    input  logic [2:0]  k0,
    output logic [19:0] ptag,
    output logic        uncached,
    output logic        ex,
    output logic [4:0]  exc_code
);

    tlb_page_t page;
    logic      mapped;
    logic      kseg1;
    logic      mem_access;

    assign page       = vaddr.tag[0] ? entry.page1 : entry.page0; // va[12] picks odd page
    assign mapped     = vaddr.tag[19:18] != 2'b10;                // kseg0/kseg1 bypass tlb
    assign kseg1      = vaddr.tag[19:17] == 3'b101;
    assign mem_access = mem_op.load | mem_op.store;

    // unmapped segments just strip the top three bits
    assign ptag = mapped ? page.pfn : {3'b000, vaddr.tag[16:0]};

    always_comb begin
        if (mapped) begin
            uncached = page.c == `CACHE_UNCACHED;
        end else if (kseg1) begin
            uncached = 1'b1;                          // kseg1 never cached
        end else begin
            uncached = k0 == `CACHE_UNCACHED;         // kseg0 follows Config.K0
        end
    end

    always_comb begin
        ex       = 1'b0;
        exc_code = `EXC_NONE;
        if (mem_access && mapped) begin
            if (!entry.found || !page.v) begin
                ex       = 1'b1;                      // refill and invalid share codes
                exc_code = mem_op.store ? `EXC_TLBS : `EXC_TLBL;
            end else if (mem_op.store && !page.d) begin
                ex       = 1'b1;
                exc_code = `EXC_MOD;
            end
        end
    end

endmodule

/* rtl/cp0_pkg.sv */
package cp0_pkg;

    // one half of a tlb entry, even or odd page
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;     // cache attribute
        logic        d;     // dirty, page writable
        logic        v;     // valid
    } tlb_page_t;

    typedef struct packed {
        logic      found;
        tlb_page_t page1;   // odd page, va[12] = 1
        tlb_page_t page0;
    } tlb_entry_t;

    // status fields in register bit order
    typedef struct packed {
        logic [7:0] im;
        logic       exl;
        logic       ie;
    } cp0_status_t;

    typedef struct packed {
        logic       bd;
        logic [7:0] ip;       // [7:2] hw lines, [1:0] sw
        logic [4:0] exc_code;
    } cp0_cause_t;

endpackage

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    typedef struct packed {
        logic [19:0] tag;      // va[31:12]
        logic [7:0]  index;    // cache set
        logic [3:0]  offset;   // byte in line
    } vaddr_t;

    // alu result is an address for load/store and the write data for mtc0
    typedef union packed {
        vaddr_t      va;
        logic [31:0] raw;
    } m1_word_u;

    typedef struct packed {
        logic load;
        logic store;
        logic is_byte;
        logic is_half;
        logic is_unsigned;
    } mem_op_t;

    typedef struct packed {
        logic [31:0] pc;
        m1_word_u    result;
        logic [31:0] rt_value;
        logic [4:0]  dest;
        logic        gr_we;
        mem_op_t     mem_op;
        logic [3:0]  wstrb;
        logic        mfc0;
        logic        mtc0;
        logic [4:0]  cp0_reg;
        logic        eret;
        logic        bd;        // sits in a delay slot
        logic        ex;        // exception from an earlier stage
        logic [4:0]  exc_code;
    } es_to_m1_bus_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] final_result;
        logic [31:0] rt_value;
        logic [4:0]  dest;
        logic        gr_we;
        mem_op_t     mem_op;
        logic        ex;
    } m1_to_ms_bus_t;

    typedef struct packed {
        logic        op;        // 1 = write
        logic [7:0]  index;
        logic [19:0] tag;       // physical
        logic [3:0]  offset;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [2:0]  load_size; // 0 byte, 1 half, 2 word
        logic        uncached;
    } dcache_req_t;

endpackage

/* rtl/m1_macros.svh */
`ifndef M1_MACROS_SVH
`define M1_MACROS_SVH

// exception codes as written to Cause.ExcCode
`define EXC_INT        5'h00
`define EXC_MOD        5'h01
`define EXC_TLBL       5'h02
`define EXC_TLBS       5'h03
`define EXC_NONE       5'h1f   // not an architectural code, marks no exception

// cp0 register numbers (select 0)
`define CP0_STATUS     5'd12
`define CP0_CAUSE      5'd13
`define CP0_EPC        5'd14
`define CP0_CONFIG     5'd16

// cache attribute as found in tlb C field and Config.K0
`define CACHE_UNCACHED 3'd2

// general exception entry, boot mode vectors
`define EXC_VECTOR     32'hbfc0_0380

`endif
